//--- verilog/sram_pkg.sv
//############################################################################
// sram package: word and address types plus the macro geometry rule
// used to tile a logical memory out of fixed-size hard macros
//############################################################################
package sram_pkg;

    localparam int DATA_W = 48;                 // logical word width
    localparam int ADDR_W = 9;                  // logical address width

    typedef logic [DATA_W-1:0] data_t;          // word, mask and read data
    typedef logic [ADDR_W-1:0] addr_t;          // logical address

    // column width of one macro
    function automatic int macro_width(input int dw);
        return (dw >= 64) ? 64 : 32;
    endfunction

    // address width of one macro, 64x64 and 128x64 parts do not exist
    function automatic int macro_aw(input int aw, input int dw);
        if (aw >= 9) return 9;
        if (aw >= 8 || dw >= 64) return 8;
        if (aw >= 7) return 7;
        return 6;
    endfunction

    // rows of macros needed to cover the address space
    function automatic int bank_count(input int aw, input int dw);
        int maw;
        maw = macro_aw(aw, dw);
        return (aw > maw) ? (2 ** (aw - maw)) : 1;
    endfunction

endpackage

//--- verilog/macro_if.sv
//############################################################################
// macro bus: address, strobes, bit mask and data of one bank
//############################################################################
`timescale 1ns/10ps

interface macro_if #(
    parameter int DW  = 48,
    parameter int MAW = 9
);
    logic [MAW-1:0] addr;                       // in-bank address
    logic           ce;                         // chip enable
    logic           we;                         // write enable
    logic [DW-1:0]  wmask;                      // per bit write mask
    logic [DW-1:0]  din;                        // write data
    logic [DW-1:0]  dout;                       // read data

    modport ctrl (output addr, ce, we, wmask, din, input dout);
    modport bank (input addr, ce, we, wmask, din, output dout);

endinterface

//--- verilog/sram_macro.sv
//############################################################################
// hard macro model: single port array with bit-masked write and a
// one-cycle registered read
//############################################################################
`timescale 1ns/10ps

module sram_macro #(
    parameter int MW  = 32,                     // column width
    parameter int MAW = 9                       // macro address width
) (
    input  logic           clk,
    input  logic [MAW-1:0] addr,
    input  logic           ce,
    input  logic           we,
    input  logic [MW-1:0]  wmask,
    input  logic [MW-1:0]  din,
    output logic [MW-1:0]  dout
);

    localparam int DEPTH = 2 ** MAW;

    logic [MW-1:0] mem [DEPTH];                 // storage array

    // write merges masked bits, read registers the word
    always_ff @(posedge clk) begin
        if (ce) begin
            if (we) begin
                mem[addr] <= (mem[addr] & ~wmask) | (din & wmask);
            end else begin
                dout <= mem[addr];              // holds when idle or writing
            end
        end
    end

endmodule

//--- verilog/spram_bank.sv
//############################################################################
// memory bank: one row of macro columns across the full word, with the
// unused top bits of the last column tied off
//############################################################################
`timescale 1ns/10ps

module spram_bank
    import sram_pkg::*;
#(
    parameter int DW  = 48,                     // logical word width
    parameter int MAW = 9                       // macro address width
) (
    input logic   clk,
    macro_if.bank bus
);

    localparam int MW   = macro_width(DW);
    localparam int NCOL = (DW + MW - 1) / MW;   // columns, rounded up
    localparam int PW   = NCOL * MW;            // padded word width

    logic [PW-1:0] din_pad;
    logic [PW-1:0] mask_pad;
    logic [PW-1:0] dout_pad;

    // zero data and zero mask in the pad bits
    assign din_pad  = PW'(bus.din);
    assign mask_pad = PW'(bus.wmask);

    assign bus.dout = dout_pad[DW-1:0];         // pad bits dropped

    for (genvar c = 0; c < NCOL; c++) begin : g_col
        sram_macro #(
            .MW (MW),
            .MAW(MAW)
        ) u_macro (
            .clk  (clk),
            .addr (bus.addr),
            .ce   (bus.ce),
            .we   (bus.we),
            .wmask(mask_pad[c*MW +: MW]),
            .din  (din_pad[c*MW +: MW]),
            .dout (dout_pad[c*MW +: MW])
        );
    end

endmodule

//--- verilog/spram.sv
//############################################################################
// single port SRAM wrapper: tiles banks of hard macros, decodes the bank
// from the upper address bits and steers read data by a registered index
//############################################################################
`timescale 1ns/10ps

module spram
    import sram_pkg::*;
#(
    parameter int DW = 48,                      // logical word width
    parameter int AW = 9                        // logical address width
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  ce,
    input  logic  we,
    input  data_t wmask,
    input  addr_t addr,
    input  data_t din,
    output data_t dout,
    output logic  rd_valid
);

    localparam int MAW = macro_aw(AW, DW);
    localparam int NB  = bank_count(AW, DW);
    localparam int BW  = (NB > 1) ? $clog2(NB) : 1;

    logic [NB-1:0] bank_sel;                    // one-hot bank enable
    logic [BW-1:0] bank_idx;                    // bank of current access
    logic [BW-1:0] bank_q;                      // bank of read in flight
    logic          rd_cyc;
    data_t         bank_dout [NB];

    // bank decode
    if (NB > 1) begin : g_decode
        assign bank_idx = addr[AW-1:MAW];
        assign bank_sel = NB'(1) << bank_idx;
    end else begin : g_single
        assign bank_idx = '0;
        assign bank_sel = 1'b1;                 // the only bank is always hit
    end

    assign rd_cyc = ce & ~we;

    for (genvar b = 0; b < NB; b++) begin : g_bank
        macro_if #(
            .DW (DW),
            .MAW(MAW)
        ) bus ();

        // shared address and data, per bank strobes
        assign bus.addr  = MAW'(addr);
        assign bus.ce    = ce & bank_sel[b];
        assign bus.we    = we & bank_sel[b];
        assign bus.wmask = wmask;
        assign bus.din   = din;

        assign bank_dout[b] = bus.dout;

        spram_bank #(
            .DW (DW),
            .MAW(MAW)
        ) u_bank (
            .clk(clk),
            .bus(bus.bank)
        );
    end

    // aligned with the one-cycle macro read
    always_ff @(posedge clk) begin
        if (rst) begin
            bank_q   <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_cyc;
            if (rd_cyc) begin
                bank_q <= bank_idx;             // held across writes and idles
            end
        end
    end

    // read steering from the registered index
    assign dout = bank_dout[bank_q];

endmodule

//--- verilog/mem_top.sv
//############################################################################
// memory top level: fixes the geometry and exposes the SRAM on plain ports
//############################################################################
`timescale 1ns/10ps

module mem_top
    import sram_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  ce,                           // chip enable
    input  logic  we,                           // write enable
    input  data_t wmask,                        // per bit write mask
    input  addr_t addr,
    input  data_t din,
    output data_t dout,
    output logic  rd_valid                      // one cycle after a read
);

    spram #(
        .DW(DATA_W),
        .AW(ADDR_W)
    ) u_spram (
        .clk     (clk),
        .rst     (rst),
        .ce      (ce),
        .we      (we),
        .wmask   (wmask),
        .addr    (addr),
        .din     (din),
        .dout    (dout),
        .rd_valid(rd_valid)
    );

endmodule

//--- verif/spram_chk.sv
//############################################################################
// wrapper checker: read valid timing against the strobes and reset
//############################################################################
`timescale 1ns/10ps

module spram_chk (
    input logic clk,
    input logic rst,
    input logic ce,
    input logic we,
    input logic rd_valid
);

    // a read raises rd_valid on the next cycle
    a_rd_follows: assert property (@(posedge clk) disable iff (rst)
        (ce && !we) |=> rd_valid)
        else $error("rd_valid missing one cycle after a read");

    // writes and idle cycles never raise rd_valid
    a_no_spurious: assert property (@(posedge clk) disable iff (rst)
        !(ce && !we) |=> !rd_valid)
        else $error("rd_valid high after a write or idle cycle");

    a_reset_low: assert property (@(posedge clk)
        rst |=> !rd_valid)
        else $error("rd_valid high in the cycle after reset");

endmodule

//--- verif/tb_mem_top.sv
//############################################################################
// memory testbench: table of directed operations, then a random phase
// checked against a shadow memory
//############################################################################
`timescale 1ns/10ps

module tb_mem_top;
    import sram_pkg::*;

    localparam int PERIOD  = 8;
    localparam int RST_CYC = 2;
    localparam int N_RAND  = 200;
    localparam int DEPTH   = 2 ** ADDR_W;
    localparam int N_POOL  = 32;                // random words spread over the array
    localparam int MAW     = macro_aw(ADDR_W, DATA_W);
    localparam int NB      = bank_count(ADDR_W, DATA_W);

    typedef struct {
        string name;
        bit    ce;
        bit    we;
        addr_t addr;
        data_t wmask;
        data_t din;
        data_t exp;                             // expected read data
    } op_t;

    logic  clk;
    logic  rst;
    logic  ce;
    logic  we;
    data_t wmask;
    addr_t addr;
    data_t din;
    data_t dout;
    logic  rd_valid;

    op_t   tbl[$];
    data_t shadow [DEPTH];
    bit    written [DEPTH];
    bit    pend_read;                           // last op was a read
    data_t pend_exp;
    string pend_name;
    data_t last_dout;
    bit    have_dout;

    mem_top dut (
        .clk     (clk),
        .rst     (rst),
        .ce      (ce),
        .we      (we),
        .wmask   (wmask),
        .addr    (addr),
        .din     (din),
        .dout    (dout),
        .rd_valid(rd_valid)
    );

    bind spram spram_chk u_chk (
        .clk     (clk),
        .rst     (rst),
        .ce      (ce),
        .we      (we),
        .rd_valid(rd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic data_t masked_merge(input data_t old_w, input data_t new_w,
                                           input data_t mask);
        data_t res;
        for (int i = 0; i < DATA_W; i++) begin
            res[i] = mask[i] ? new_w[i] : old_w[i];   // new bit only where masked in
        end
        return res;
    endfunction

    task automatic add_op(input string name, input bit op_ce, input bit op_we,
                          input addr_t op_addr, input data_t op_mask,
                          input data_t op_din, input data_t op_exp);
        op_t op;
        op.name  = name;
        op.ce    = op_ce;
        op.we    = op_we;
        op.addr  = op_addr;
        op.wmask = op_mask;
        op.din   = op_din;
        op.exp   = op_exp;
        tbl.push_back(op);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
            $display("Test failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // checks the previous operation one clock after issue
    task automatic check_prev();
        if (pend_read) begin
            check_value({pend_name, " rd_valid"}, 64'd1, 64'(rd_valid));
            check_value({pend_name, " dout"}, 64'(pend_exp), 64'(dout));
            last_dout = pend_exp;
            have_dout = 1'b1;
        end else begin
            check_value({pend_name, " rd_valid"}, 64'd0, 64'(rd_valid));
            if (have_dout) begin
                check_value({pend_name, " dout held"}, 64'(last_dout), 64'(dout));
            end
        end
    endtask

    task automatic run_op(input op_t op);
        @(posedge clk);
        #1;
        check_prev();
        ce    = op.ce;
        we    = op.we;
        addr  = op.addr;
        wmask = op.wmask;
        din   = op.din;
        if (op.ce && op.we) begin
            shadow[op.addr]  = masked_merge(shadow[op.addr], op.din, op.wmask);
            written[op.addr] = 1'b1;
        end
        pend_read = op.ce && !op.we;
        pend_exp  = op.exp;
        pend_name = op.name;
    endtask

    task automatic build_table();
        addr_t lo;
        addr_t hi;
        data_t full;
        full = '1;
        for (int b = 0; b < NB; b++) begin   // first and last word of each bank
            lo = addr_t'(b << MAW);
            hi = addr_t'(((b + 1) << MAW) - 1);
            add_op($sformatf("wr_first_b%0d", b), 1, 1, lo, full, 48'h1111_2222_0000 | b, '0);
            add_op($sformatf("wr_last_b%0d", b), 1, 1, hi, full, 48'hEEEE_DDDD_0000 | b, '0);
            add_op($sformatf("rd_first_b%0d", b), 1, 0, lo, '0, '0, 48'h1111_2222_0000 | b);
            add_op($sformatf("rd_last_b%0d", b), 1, 0, hi, '0, '0, 48'hEEEE_DDDD_0000 | b);
        end
        add_op("wr_base", 1, 1, 9'h05A, full, 48'h0123_4567_89AB, '0);
        add_op("wr_ends", 1, 1, 9'h05A, 48'hFFFF_0000_FFFF, 48'hAAAA_BBBB_CCCC, '0);
        add_op("rd_ends", 1, 0, 9'h05A, '0, '0, 48'hAAAA_4567_CCCC);
        add_op("wr_alt", 1, 1, 9'h05A, 48'h5555_5555_5555, 48'hFFFF_FFFF_FFFF, '0);
        add_op("rd_alt", 1, 0, 9'h05A, '0, '0, 48'hFFFF_5577_DDDD);
        add_op("wr_pad_col", 1, 1, 9'h05A, 48'hAAAA_0000_0000, '0, '0);
        add_op("rd_pad_col", 1, 0, 9'h05A, '0, '0, 48'h5555_5577_DDDD);
        // back to back reads across the address range
        add_op("b2b_first", 1, 0, '0, '0, '0, 48'h1111_2222_0000);
        add_op("b2b_last", 1, 0, '1, '0, '0, 48'hEEEE_DDDD_0000 | (NB - 1));
        add_op("b2b_mid", 1, 0, 9'h05A, '0, '0, 48'h5555_5577_DDDD);
        add_op("idle", 0, 0, 9'h05A, '0, '0, '0);
        add_op("no_ce_write", 0, 1, 9'h05A, full, '0, '0);
        add_op("wr_other", 1, 1, 9'h100, full, 48'h0F0F_F0F0_1234, '0);
        add_op("rd_no_ce", 1, 0, 9'h05A, '0, '0, 48'h5555_5577_DDDD);
        add_op("rd_other", 1, 0, 9'h100, '0, '0, 48'h0F0F_F0F0_1234);
    endtask

    initial begin
        ce        = 1'b0;
        we        = 1'b0;
        wmask     = '0;
        addr      = '0;
        din       = '0;
        rst       = 1'b1;
        pend_read = 1'b0;
        pend_exp  = '0;
        pend_name = "reset";
        have_dout = 1'b0;
        void'($urandom(20));
        build_table();
        repeat (RST_CYC) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("after_reset rd_valid", 64'd0, 64'(rd_valid));
        foreach (tbl[i]) begin
            run_op(tbl[i]);
        end
        for (int i = 0; i < N_RAND; i++) begin
            op_t op;
            op.name  = $sformatf("rand_%0d", i);
            op.addr  = addr_t'(($urandom % N_POOL) * (DEPTH / N_POOL));
            op.ce    = ($urandom % 8) != 0;         // occasional idle
            op.we    = !written[op.addr] || ($urandom % 2);
            op.wmask = written[op.addr] ? data_t'({$urandom, $urandom}) : '1;
            op.din   = data_t'({$urandom, $urandom});
            op.exp   = shadow[op.addr];
            run_op(op);
        end
        run_op('{name: "drain", ce: 0, we: 0, addr: '0, wmask: '0, din: '0, exp: '0});
        @(posedge clk);
        #1;
        check_prev();
        $display("Test passed");
        $finish;
    end

    // watchdog sized from the number of operations
    initial begin
        int limit;
        #1;
        limit = (tbl.size() + N_RAND + RST_CYC + 4) * PERIOD + 100;
        #(limit);
        $display("Simulation hung: no end of test within %0d ns", limit);
        $display("Test failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- project.f
verilog/sram_pkg.sv
verilog/macro_if.sv
verilog/sram_macro.sv
verilog/spram_bank.sv
verilog/spram.sv
verilog/mem_top.sv
verif/spram_chk.sv
verif/tb_mem_top.sv
